// ==== verilog/la32r_consts.svh ====
`ifndef LA32R_CONSTS_SVH
`define LA32R_CONSTS_SVH

// datapath widths
`define LA32R_WORD_W      32
`define LA32R_REG_ADDR_W  5
`define LA32R_ALU_OP_W    12
`define LA32R_IMM12_W     12
`define LA32R_IMM20_W     20

// opcode field lengths counted from bit 31 down
`define LA32R_OP6_W   6
`define LA32R_OP7_W   7
`define LA32R_OP10_W  10
`define LA32R_OP17_W  17

// 3r and shift-immediate ops in inst[31:15]
`define LA32R_OP_ADD_W   17'h00020
`define LA32R_OP_SUB_W   17'h00022
`define LA32R_OP_SLT     17'h00024
`define LA32R_OP_SLTU    17'h00025
`define LA32R_OP_NOR     17'h00028
`define LA32R_OP_AND     17'h00029
`define LA32R_OP_OR      17'h0002a
`define LA32R_OP_XOR     17'h0002b
`define LA32R_OP_SLL_W   17'h0002e
`define LA32R_OP_SRL_W   17'h0002f
`define LA32R_OP_SRA_W   17'h00030
`define LA32R_OP_SLLI_W  17'h00081
`define LA32R_OP_SRLI_W  17'h00089
`define LA32R_OP_SRAI_W  17'h00091

// 2ri12 ops in inst[31:22]
`define LA32R_OP_SLTI    10'h008
`define LA32R_OP_SLTUI   10'h009
`define LA32R_OP_ADDI_W  10'h00a
`define LA32R_OP_ANDI    10'h00d
`define LA32R_OP_ORI     10'h00e
`define LA32R_OP_XORI    10'h00f
`define LA32R_OP_LD_W    10'h0a2
`define LA32R_OP_ST_W    10'h0a6

// 1ri20 ops in inst[31:25]
`define LA32R_OP_LU12I_W    7'h0a
`define LA32R_OP_PCADDU12I  7'h0e

// jump and branch ops in inst[31:26]
`define LA32R_OP_JIRL  6'h13
`define LA32R_OP_B     6'h14
`define LA32R_OP_BL    6'h15
`define LA32R_OP_BEQ   6'h16
`define LA32R_OP_BNE   6'h17
`define LA32R_OP_BLT   6'h18
`define LA32R_OP_BGE   6'h19
`define LA32R_OP_BLTU  6'h1a
`define LA32R_OP_BGEU  6'h1b

// link register and return increment
`define LA32R_LINK_REG     5'd1
`define LA32R_LINK_OFFSET  32'd4

`endif

// ==== verilog/la32r_isa_pkg.sv ====
`include "la32r_consts.svh"

package la32r_isa_pkg;

    // one data word or byte address
    typedef logic [`LA32R_WORD_W-1:0] word_t;

    // raw instruction word as fetched
    typedef logic [`LA32R_WORD_W-1:0] inst_t;

    // architectural register number
    typedef logic [`LA32R_REG_ADDR_W-1:0] reg_addr_t;

    // si12 or ui12 field of the 2ri12 format
    typedef logic [`LA32R_IMM12_W-1:0] imm12_t;

    // si20 field of lu12i.w and pcaddu12i
    typedef logic [`LA32R_IMM20_W-1:0] imm20_t;

endpackage

// ==== verilog/id_ctrl_pkg.sv ====
`include "la32r_consts.svh"

package id_ctrl_pkg;

    // one-hot alu op from msb down
    // add sub slt sltu and nor or xor sll srl sra lui
    typedef logic [`LA32R_ALU_OP_W-1:0] alu_op_t;

    // immediate extension kind
    // bit 2 zero-ext 12, bit 1 sign-ext 12, bit 0 upper 20
    typedef logic [2:0] imm_kind_t;

    // operand overrides
    // bit 1 pc as src1, bit 0 link constant as src2
    typedef logic [1:0] src_sel_t;

    // conditional branch hits from msb down
    // beq bne blt bge bltu bgeu
    typedef logic [5:0] br_cond_t;

endpackage

// ==== verilog/id_inst_decode.sv ====
`timescale 1ns/1ps
`include "la32r_consts.svh"

module id_inst_decode (
    input  la32r_isa_pkg::inst_t     inst_i,
    input  logic                     valid_i,
    output id_ctrl_pkg::alu_op_t     alu_op_o,
    output id_ctrl_pkg::imm_kind_t   imm_kind_o,
    output id_ctrl_pkg::src_sel_t    src_sel_o,
    output logic                     shf_imm_o,
    output logic                     is_load_o,
    output logic                     is_store_o,
    output logic                     is_jump_o,
    output logic                     is_jr_o,
    output id_ctrl_pkg::br_cond_t    br_cond_o,
    output logic                     reads_rj_o,
    output logic                     reads_rk_o,
    output la32r_isa_pkg::reg_addr_t rj_addr_o,
    output la32r_isa_pkg::reg_addr_t rk_addr_o,
    output logic                     wb_we_o,
    output la32r_isa_pkg::reg_addr_t wb_addr_o
);

    // opcode fields of each format length
    wire [`LA32R_OP6_W-1:0]  op6  = inst_i[31:26];
    wire [`LA32R_OP7_W-1:0]  op7  = inst_i[31:25];
    wire [`LA32R_OP10_W-1:0] op10 = inst_i[31:22];
    wire [`LA32R_OP17_W-1:0] op17 = inst_i[31:15];

    // register fields
    wire [4:0] rd = inst_i[4:0];
    wire [4:0] rj = inst_i[9:5];
    wire [4:0] rk = inst_i[14:10];

    // per-instruction hits, all masked by valid
    wire i_add_w   = valid_i && (op17 == `LA32R_OP_ADD_W);
    wire i_sub_w   = valid_i && (op17 == `LA32R_OP_SUB_W);
    wire i_slt     = valid_i && (op17 == `LA32R_OP_SLT);
    wire i_sltu    = valid_i && (op17 == `LA32R_OP_SLTU);
    wire i_nor     = valid_i && (op17 == `LA32R_OP_NOR);
    wire i_and     = valid_i && (op17 == `LA32R_OP_AND);
    wire i_or      = valid_i && (op17 == `LA32R_OP_OR);
    wire i_xor     = valid_i && (op17 == `LA32R_OP_XOR);
    wire i_sll_w   = valid_i && (op17 == `LA32R_OP_SLL_W);
    wire i_srl_w   = valid_i && (op17 == `LA32R_OP_SRL_W);
    wire i_sra_w   = valid_i && (op17 == `LA32R_OP_SRA_W);
    wire i_slli_w  = valid_i && (op17 == `LA32R_OP_SLLI_W);
    wire i_srli_w  = valid_i && (op17 == `LA32R_OP_SRLI_W);
    wire i_srai_w  = valid_i && (op17 == `LA32R_OP_SRAI_W);
    wire i_slti    = valid_i && (op10 == `LA32R_OP_SLTI);
    wire i_sltui   = valid_i && (op10 == `LA32R_OP_SLTUI);
    wire i_addi_w  = valid_i && (op10 == `LA32R_OP_ADDI_W);
    wire i_andi    = valid_i && (op10 == `LA32R_OP_ANDI);
    wire i_ori     = valid_i && (op10 == `LA32R_OP_ORI);
    wire i_xori    = valid_i && (op10 == `LA32R_OP_XORI);
    wire i_ld_w    = valid_i && (op10 == `LA32R_OP_LD_W);
    wire i_st_w    = valid_i && (op10 == `LA32R_OP_ST_W);
    wire i_lu12i_w = valid_i && (op7 == `LA32R_OP_LU12I_W);
    wire i_pcaddu  = valid_i && (op7 == `LA32R_OP_PCADDU12I);
    wire i_jirl    = valid_i && (op6 == `LA32R_OP_JIRL);
    wire i_b       = valid_i && (op6 == `LA32R_OP_B);
    wire i_bl      = valid_i && (op6 == `LA32R_OP_BL);

    // link instructions write pc+4
    wire link = i_bl | i_jirl;
    wire ui20 = i_lu12i_w | i_pcaddu;
    wire alu_imm12 = i_slti | i_sltui | i_addi_w | i_andi | i_ori | i_xori;

    // conditional branches in br_cond_t order
    assign br_cond_o = {
        valid_i && (op6 == `LA32R_OP_BEQ),
        valid_i && (op6 == `LA32R_OP_BNE),
        valid_i && (op6 == `LA32R_OP_BLT),
        valid_i && (op6 == `LA32R_OP_BGE),
        valid_i && (op6 == `LA32R_OP_BLTU),
        valid_i && (op6 == `LA32R_OP_BGEU)
    };

    assign is_jr_o    = i_jirl;
    assign is_jump_o  = i_jirl | i_b | i_bl | (|br_cond_o);
    assign is_load_o  = i_ld_w;
    assign is_store_o = i_st_w;
    assign shf_imm_o  = i_slli_w | i_srli_w | i_srai_w;

    // address arithmetic of loads, stores and links goes through add
    assign alu_op_o = {
        i_add_w | i_addi_w | i_ld_w | i_st_w | link | i_pcaddu,
        i_sub_w,
        i_slt | i_slti,
        i_sltu | i_sltui,
        i_and | i_andi,
        i_nor,
        i_or | i_ori,
        i_xor | i_xori,
        i_sll_w | i_slli_w,
        i_srl_w | i_srli_w,
        i_sra_w | i_srai_w,
        i_lu12i_w
    };

    assign imm_kind_o = {
        i_andi | i_ori | i_xori,
        i_addi_w | i_slti | i_sltui | i_ld_w | i_st_w,
        ui20
    };
    assign src_sel_o = {link | i_pcaddu, link};

    // sources actually read from the register file
    assign reads_rj_o = ~(ui20 | i_b | i_bl);
    assign reads_rk_o = ~(shf_imm_o | alu_imm12 | i_ld_w | i_b | i_bl | ui20);

    // compares and st.w take rd on the second port
    assign rj_addr_o = rj;
    assign rk_addr_o = ((|br_cond_o) | i_st_w) ? rd : rk;

    // b, conditional branches and st.w write nothing
    assign wb_we_o   = valid_i & ~(i_b | (|br_cond_o) | i_st_w);
    assign wb_addr_o = !wb_we_o ? '0 : (i_bl ? `LA32R_LINK_REG : rd);

endmodule

// ==== verilog/id_operand_mux.sv ====
`timescale 1ns/1ps
`include "la32r_consts.svh"

module id_operand_mux (
    input  la32r_isa_pkg::inst_t   inst_i,
    input  la32r_isa_pkg::word_t   pc_i,
    input  la32r_isa_pkg::word_t   rj_data_i,
    input  la32r_isa_pkg::word_t   rk_data_i,
    input  id_ctrl_pkg::imm_kind_t imm_kind_i,
    input  id_ctrl_pkg::src_sel_t  src_sel_i,
    input  logic                   shf_imm_i,
    output la32r_isa_pkg::word_t   src1_o,
    output la32r_isa_pkg::word_t   src2_o
);

    la32r_isa_pkg::imm12_t imm12;
    la32r_isa_pkg::imm20_t imm20;

    // si12 sits at [21:10], si20 at [24:5]
    assign imm12 = inst_i[21:10];
    assign imm20 = inst_i[24:5];

    // pc feeds the adder for links and pcaddu12i
    assign src1_o = src_sel_i[1] ? pc_i : rj_data_i;

    // first match wins
    always_comb begin
        if (src_sel_i[0]) begin
            src2_o = `LA32R_LINK_OFFSET;
        end else if (imm_kind_i[2]) begin
            src2_o = {20'd0, imm12};
        end else if (imm_kind_i[1]) begin
            src2_o = {{20{imm12[11]}}, imm12};
        end else if (imm_kind_i[0]) begin
            src2_o = {imm20, 12'd0};
        end else if (shf_imm_i) begin
            // ui5 shift amount in the rk slot
            src2_o = {27'd0, inst_i[14:10]};
        end else begin
            src2_o = rk_data_i;
        end
    end

endmodule

// ==== verilog/id_branch_unit.sv ====
`timescale 1ns/1ps

module id_branch_unit (
    input  la32r_isa_pkg::inst_t  inst_i,
    input  la32r_isa_pkg::word_t  pc_i,
    input  la32r_isa_pkg::word_t  rj_data_i,
    input  la32r_isa_pkg::word_t  rk_data_i,
    input  logic                  is_jump_i,
    input  logic                  is_jr_i,
    input  id_ctrl_pkg::br_cond_t br_cond_i,
    input  logic                  id_over_i,
    output logic                  jbr_taken_o,
    output la32r_isa_pkg::word_t  jbr_target_o
);

    la32r_isa_pkg::word_t off16;
    la32r_isa_pkg::word_t off26;
    logic is_br;
    logic uncond;
    logic rj_eq_rk;
    logic rj_lt_s;
    logic rj_lt_u;
    logic cond_ok;

    // word offsets, sign-extended
    // offs26 is split with the high part in [9:0]
    assign off16 = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
    assign off26 = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};

    // jirl, b and bl always redirect
    assign is_br  = |br_cond_i;
    assign uncond = is_jump_i & ~is_br;

    // rk port carries rd for compares
    assign rj_eq_rk = (rj_data_i == rk_data_i);
    assign rj_lt_s  = ($signed(rj_data_i) < $signed(rk_data_i));
    assign rj_lt_u  = (rj_data_i < rk_data_i);

    assign cond_ok = (br_cond_i[5] &  rj_eq_rk)
                   | (br_cond_i[4] & ~rj_eq_rk)
                   | (br_cond_i[3] &  rj_lt_s)
                   | (br_cond_i[2] & ~rj_lt_s)
                   | (br_cond_i[1] &  rj_lt_u)
                   | (br_cond_i[0] & ~rj_lt_u);

    // jirl is register relative, the rest pc relative
    always_comb begin
        if (is_jr_i) begin
            jbr_target_o = rj_data_i + off16;
        end else if (is_br) begin
            jbr_target_o = pc_i + off16;
        end else begin
            jbr_target_o = pc_i + off26;
        end
    end

    // no redirect until decode has completed
    assign jbr_taken_o = id_over_i & (uncond | cond_ok);

endmodule

// ==== verilog/id_hazard_unit.sv ====
`timescale 1ns/1ps

module id_hazard_unit (
    input  logic                     valid_i,
    input  la32r_isa_pkg::reg_addr_t rj_addr_i,
    input  la32r_isa_pkg::reg_addr_t rk_addr_i,
    input  logic                     reads_rj_i,
    input  logic                     reads_rk_i,
    input  logic                     is_jump_i,
    input  la32r_isa_pkg::reg_addr_t ex_dest_i,
    input  la32r_isa_pkg::reg_addr_t mem_dest_i,
    input  la32r_isa_pkg::reg_addr_t wb_dest_i,
    input  logic                     if_over_i,
    output logic                     id_over_o
);

    logic rj_hazard;
    logic rk_hazard;

    // r0 never conflicts, a zero dest means no write
    assign rj_hazard = reads_rj_i && (rj_addr_i != '0)
                    && ((rj_addr_i == ex_dest_i) || (rj_addr_i == mem_dest_i)
                        || (rj_addr_i == wb_dest_i));
    assign rk_hazard = reads_rk_i && (rk_addr_i != '0)
                    && ((rk_addr_i == ex_dest_i) || (rk_addr_i == mem_dest_i)
                        || (rk_addr_i == wb_dest_i));

    // jumps also wait for fetch to accept the redirect
    assign id_over_o = valid_i & ~rj_hazard & ~rk_hazard & (~is_jump_i | if_over_i);

endmodule

// ==== verilog/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     if_valid_i,
    input  la32r_isa_pkg::word_t     if_pc_i,
    input  la32r_isa_pkg::inst_t     if_inst_i,
    input  la32r_isa_pkg::word_t     rj_data_i,
    input  la32r_isa_pkg::word_t     rk_data_i,
    input  la32r_isa_pkg::reg_addr_t ex_dest_i,
    input  la32r_isa_pkg::reg_addr_t mem_dest_i,
    input  la32r_isa_pkg::reg_addr_t wb_dest_i,
    input  logic                     if_over_i,
    output logic                     allow_in_o,
    output la32r_isa_pkg::reg_addr_t rj_addr_o,
    output la32r_isa_pkg::reg_addr_t rk_addr_o,
    output id_ctrl_pkg::alu_op_t     alu_op_o,
    output la32r_isa_pkg::word_t     src1_o,
    output la32r_isa_pkg::word_t     src2_o,
    output logic                     is_load_o,
    output logic                     is_store_o,
    output la32r_isa_pkg::word_t     st_data_o,
    output logic                     wb_we_o,
    output la32r_isa_pkg::reg_addr_t wb_addr_o,
    output la32r_isa_pkg::word_t     pc_o,
    output logic                     id_over_o,
    output logic                     jbr_taken_o,
    output la32r_isa_pkg::word_t     jbr_target_o
);

    // entry register
    logic                 entry_valid;
    la32r_isa_pkg::word_t entry_pc;
    la32r_isa_pkg::inst_t entry_inst;

    // decoded control between the submodules
    id_ctrl_pkg::imm_kind_t imm_kind;
    id_ctrl_pkg::src_sel_t  src_sel;
    id_ctrl_pkg::br_cond_t  br_cond;
    logic                   shf_imm;
    logic                   is_jump;
    logic                   is_jr;
    logic                   reads_rj;
    logic                   reads_rk;

    // empty entry or one leaving this cycle
    assign allow_in_o = ~entry_valid | id_over_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            entry_valid <= 1'b0;
        end else if (allow_in_o) begin
            entry_valid <= if_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (allow_in_o) begin
            entry_pc   <= if_pc_i;
            entry_inst <= if_inst_i;
        end
    end

    assign pc_o      = entry_pc;
    assign st_data_o = rk_data_i;

    // class outputs masked inside decode by the entry valid bit
    id_inst_decode u_decode (
        .inst_i     (entry_inst),
        .valid_i    (entry_valid),
        .alu_op_o   (alu_op_o),
        .imm_kind_o (imm_kind),
        .src_sel_o  (src_sel),
        .shf_imm_o  (shf_imm),
        .is_load_o  (is_load_o),
        .is_store_o (is_store_o),
        .is_jump_o  (is_jump),
        .is_jr_o    (is_jr),
        .br_cond_o  (br_cond),
        .reads_rj_o (reads_rj),
        .reads_rk_o (reads_rk),
        .rj_addr_o  (rj_addr_o),
        .rk_addr_o  (rk_addr_o),
        .wb_we_o    (wb_we_o),
        .wb_addr_o  (wb_addr_o)
    );

    id_operand_mux u_operands (
        .inst_i     (entry_inst),
        .pc_i       (entry_pc),
        .rj_data_i  (rj_data_i),
        .rk_data_i  (rk_data_i),
        .imm_kind_i (imm_kind),
        .src_sel_i  (src_sel),
        .shf_imm_i  (shf_imm),
        .src1_o     (src1_o),
        .src2_o     (src2_o)
    );

    id_branch_unit u_branch (
        .inst_i       (entry_inst),
        .pc_i         (entry_pc),
        .rj_data_i    (rj_data_i),
        .rk_data_i    (rk_data_i),
        .is_jump_i    (is_jump),
        .is_jr_i      (is_jr),
        .br_cond_i    (br_cond),
        .id_over_i    (id_over_o),
        .jbr_taken_o  (jbr_taken_o),
        .jbr_target_o (jbr_target_o)
    );

    id_hazard_unit u_hazard (
        .valid_i    (entry_valid),
        .rj_addr_i  (rj_addr_o),
        .rk_addr_i  (rk_addr_o),
        .reads_rj_i (reads_rj),
        .reads_rk_i (reads_rk),
        .is_jump_i  (is_jump),
        .ex_dest_i  (ex_dest_i),
        .mem_dest_i (mem_dest_i),
        .wb_dest_i  (wb_dest_i),
        .if_over_i  (if_over_i),
        .id_over_o  (id_over_o)
    );

endmodule

// ==== verif/id_stage_asserts.sv ====
`timescale 1ns/1ps

module id_stage_asserts (
    input logic                     clk_i,
    input logic                     rst_n_i,
    input logic                     entry_valid_i,
    input logic                     allow_in_i,
    input logic                     id_over_i,
    input logic                     jbr_taken_i,
    input logic                     wb_we_i,
    input la32r_isa_pkg::reg_addr_t wb_addr_i
);

    // read back by the testbench at the end of the run
    int unsigned fail_count = 0;

    // accept when the entry is empty or leaving this cycle
    a_allow_in: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        allow_in_i == (!entry_valid_i || id_over_i))
        else begin
            $error("allow_in_o does not match entry valid and id_over_o");
            fail_count++;
        end

    // no redirect before decode completes
    a_taken_over: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        jbr_taken_i |-> id_over_i)
        else begin
            $error("jbr_taken_o high while id_over_o low");
            fail_count++;
        end

    a_wb_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !wb_we_i |-> (wb_addr_i == '0))
        else begin
            $error("wb_addr_o nonzero with wb_we_o low");
            fail_count++;
        end

    a_over_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(id_over_i))
        else begin
            $error("id_over_o unknown after reset");
            fail_count++;
        end

endmodule

bind id_stage id_stage_asserts u_asserts (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .entry_valid_i (entry_valid),
    .allow_in_i    (allow_in_o),
    .id_over_i     (id_over_o),
    .jbr_taken_i   (jbr_taken_o),
    .wb_we_i       (wb_we_o),
    .wb_addr_i     (wb_addr_o)
);

// ==== verif/id_stage_tb.sv ====
`timescale 1ns/1ps
`include "la32r_consts.svh"

module id_stage_tb;

    // one table row, the entry instruction of one cycle
    typedef struct packed {
        la32r_isa_pkg::inst_t     inst;
        la32r_isa_pkg::word_t     pc;
        logic [14:0]              dst;
        logic                     ifo;
        logic                     nw;
        logic                     tie;
        id_ctrl_pkg::alu_op_t     op;
        la32r_isa_pkg::reg_addr_t wa;
        logic [4:0]               flg;
        logic                     s1;
        logic [2:0]               s2;
        logic [1:0]               tk;
        logic [2:0]               cd;
    } row_t;

    logic                     clk_i;
    logic                     rst_n_i;
    logic                     if_valid_i;
    la32r_isa_pkg::word_t     if_pc_i;
    la32r_isa_pkg::inst_t     if_inst_i;
    la32r_isa_pkg::word_t     rj_data_i;
    la32r_isa_pkg::word_t     rk_data_i;
    la32r_isa_pkg::reg_addr_t ex_dest_i;
    la32r_isa_pkg::reg_addr_t mem_dest_i;
    la32r_isa_pkg::reg_addr_t wb_dest_i;
    logic                     if_over_i;
    logic                     allow_in_o;
    la32r_isa_pkg::reg_addr_t rj_addr_o;
    la32r_isa_pkg::reg_addr_t rk_addr_o;
    id_ctrl_pkg::alu_op_t     alu_op_o;
    la32r_isa_pkg::word_t     src1_o;
    la32r_isa_pkg::word_t     src2_o;
    logic                     is_load_o;
    logic                     is_store_o;
    la32r_isa_pkg::word_t     st_data_o;
    logic                     wb_we_o;
    la32r_isa_pkg::reg_addr_t wb_addr_o;
    la32r_isa_pkg::word_t     pc_o;
    logic                     id_over_o;
    logic                     jbr_taken_o;
    la32r_isa_pkg::word_t     jbr_target_o;

    row_t        rows[$];
    logic [14:0] next_dst = '0;
    logic [31:0] rng = 32'hbe2f_6cb5;

    id_stage dut_i (.*);

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // instruction formats, field order from bit 31 down
    function automatic la32r_isa_pkg::inst_t r3(input logic [16:0] op, input logic [4:0] rk,
                                                input logic [4:0] rj, input logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic la32r_isa_pkg::inst_t r2i12(input logic [9:0] op, input logic [11:0] imm,
                                                   input logic [4:0] rj, input logic [4:0] rd);
        return {op, imm, rj, rd};
    endfunction

    function automatic la32r_isa_pkg::inst_t r1i20(input logic [6:0] op, input logic [19:0] imm,
                                                   input logic [4:0] rd);
        return {op, imm, rd};
    endfunction

    function automatic la32r_isa_pkg::inst_t r2i16(input logic [5:0] op, input logic [15:0] offs,
                                                   input logic [4:0] rj, input logic [4:0] rd);
        return {op, offs, rj, rd};
    endfunction

    // offs26 low half in [25:10], high part in [9:0]
    function automatic la32r_isa_pkg::inst_t i26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic add_row(input la32r_isa_pkg::inst_t inst, input logic [2:0] ctl,
                           input id_ctrl_pkg::alu_op_t op, input la32r_isa_pkg::reg_addr_t wa,
                           input logic [4:0] flg, input logic s1, input logic [2:0] s2,
                           input logic [1:0] tk, input logic [2:0] cd);
        row_t e;
        e = '{inst: inst, pc: '0, dst: next_dst, ifo: ctl[2], nw: ctl[1], tie: ctl[0],
              op: op, wa: wa, flg: flg, s1: s1, s2: s2, tk: tk, cd: cd};
        // a held row keeps the pc of the row before
        if (ctl[1]) begin
            e.pc = 32'h1c00_0000 + 32'(rows.size() * 4);
        end else if (rows.size() > 0) begin
            e.pc = rows[rows.size() - 1].pc;
        end
        rows.push_back(e);
        next_dst = '0;
    endtask

    task automatic report_mismatch(input string name, input string exp_s, input string act_s);
        $display("FAIL time %0t: %s expected %s actual %s", $time, name, exp_s, act_s);
        $display("STATUS: FAIL");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic word_eq(input string name, input la32r_isa_pkg::word_t exp,
                           input la32r_isa_pkg::word_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic addr_eq(input string name, input la32r_isa_pkg::reg_addr_t exp,
                           input la32r_isa_pkg::reg_addr_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic op_eq(input string name, input id_ctrl_pkg::alu_op_t exp,
                         input id_ctrl_pkg::alu_op_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic bit_eq(input string name, input logic exp, input logic act);
        if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic build_table();
        // ctl {if_over, new, tie}  flg {valid, we, load, store, over}
        // s1 0 rj 1 pc  s2 0 rk 1 link 2 zx12 3 sx12 4 ui20 5 ui5
        // tk 0 none 1 jirl 2 offs26 3 offs16  cd 0 never 1 always 2 eq 3 ne 4 lt 5 ge 6 ltu 7 geu
        add_row('0, 3'b100, 12'h000, 0, 5'b00000, 0, 0, 0, 0);
        add_row(r3(`LA32R_OP_ADD_W, 7, 6, 4), 3'b110, 12'h800, 4, 5'b11001, 0, 0, 0, 0);
        // rj is r0 while every dest is 0
        add_row(r3(`LA32R_OP_SUB_W, 7, 0, 4), 3'b110, 12'h400, 4, 5'b11001, 0, 0, 0, 0);
        add_row(r3(`LA32R_OP_SLT, 7, 6, 4), 3'b110, 12'h200, 4, 5'b11001, 0, 0, 0, 0);
        add_row(r3(`LA32R_OP_SLTU, 7, 6, 4), 3'b110, 12'h100, 4, 5'b11001, 0, 0, 0, 0);
        add_row(r3(`LA32R_OP_AND, 7, 6, 4), 3'b110, 12'h080, 4, 5'b11001, 0, 0, 0, 0);
        add_row(r3(`LA32R_OP_NOR, 7, 6, 4), 3'b110, 12'h040, 4, 5'b11001, 0, 0, 0, 0);
        add_row(r3(`LA32R_OP_OR, 7, 6, 4), 3'b110, 12'h020, 4, 5'b11001, 0, 0, 0, 0);
        add_row(r3(`LA32R_OP_XOR, 7, 6, 4), 3'b110, 12'h010, 4, 5'b11001, 0, 0, 0, 0);
        add_row(r3(`LA32R_OP_SLL_W, 7, 6, 4), 3'b110, 12'h008, 4, 5'b11001, 0, 0, 0, 0);
        add_row(r3(`LA32R_OP_SRL_W, 7, 6, 4), 3'b110, 12'h004, 4, 5'b11001, 0, 0, 0, 0);
        add_row(r3(`LA32R_OP_SRA_W, 7, 6, 4), 3'b110, 12'h002, 4, 5'b11001, 0, 0, 0, 0);
        // mem dest hits the ui5 slot, which is not a source
        next_dst = {5'd0, 5'd3, 5'd0};
        add_row(r3(`LA32R_OP_SLLI_W, 3, 6, 4), 3'b110, 12'h008, 4, 5'b11001, 0, 5, 0, 0);
        add_row(r3(`LA32R_OP_SRLI_W, 31, 6, 4), 3'b110, 12'h004, 4, 5'b11001, 0, 5, 0, 0);
        add_row(r3(`LA32R_OP_SRAI_W, 17, 6, 4), 3'b110, 12'h002, 4, 5'b11001, 0, 5, 0, 0);
        add_row(r2i12(`LA32R_OP_SLTI, 12'h800, 6, 4), 3'b110, 12'h200, 4, 5'b11001, 0, 3, 0, 0);
        add_row(r2i12(`LA32R_OP_SLTUI, 12'h7ff, 6, 4), 3'b110, 12'h100, 4, 5'b11001, 0, 3, 0, 0);
        add_row(r2i12(`LA32R_OP_ADDI_W, 12'hf9c, 6, 4), 3'b110, 12'h800, 4, 5'b11001, 0, 3, 0, 0);
        add_row(r2i12(`LA32R_OP_ANDI, 12'hf0f, 6, 4), 3'b110, 12'h080, 4, 5'b11001, 0, 2, 0, 0);
        add_row(r2i12(`LA32R_OP_ORI, 12'h8a5, 6, 4), 3'b110, 12'h020, 4, 5'b11001, 0, 2, 0, 0);
        // xori must ignore its rk slot (19)
        next_dst = {5'd0, 5'd0, 5'd19};
        add_row(r2i12(`LA32R_OP_XORI, 12'hc33, 6, 4), 3'b110, 12'h010, 4, 5'b11001, 0, 2, 0, 0);
        // lu12i.w does not read its rj slot (30)
        next_dst = {5'd30, 5'd0, 5'd0};
        add_row(r1i20(`LA32R_OP_LU12I_W, 20'habcde, 4), 3'b110, 12'h001, 4, 5'b11001, 0, 4, 0, 0);
        add_row(r1i20(`LA32R_OP_PCADDU12I, 20'h123, 4), 3'b110, 12'h800, 4, 5'b11001, 1, 4, 0, 0);
        add_row(r2i12(`LA32R_OP_LD_W, 12'hffc, 6, 4), 3'b110, 12'h800, 4, 5'b11101, 0, 3, 0, 0);
        add_row(r2i12(`LA32R_OP_ST_W, 12'h010, 6, 4), 3'b110, 12'h800, 0, 5'b10011, 0, 3, 0, 0);
        add_row(r2i16(`LA32R_OP_JIRL, 16'hfff0, 6, 4), 3'b110, 12'h800, 4, 5'b11001, 1, 1, 1, 1);
        add_row(i26(`LA32R_OP_B, 26'h3ff_fffc), 3'b110, 12'h000, 0, 5'b10001, 0, 0, 2, 1);
        add_row(i26(`LA32R_OP_BL, 26'h000_1234), 3'b110, 12'h800, 1, 5'b11001, 1, 1, 2, 1);
        add_row(r2i16(`LA32R_OP_BEQ, 16'h0010, 6, 4), 3'b111, 12'h000, 0, 5'b10001, 0, 0, 3, 2);
        add_row(r2i16(`LA32R_OP_BNE, 16'hffe0, 6, 4), 3'b110, 12'h000, 0, 5'b10001, 0, 0, 3, 3);
        add_row(r2i16(`LA32R_OP_BLT, 16'h0020, 6, 4), 3'b110, 12'h000, 0, 5'b10001, 0, 0, 3, 4);
        add_row(r2i16(`LA32R_OP_BGE, 16'h8000, 6, 4), 3'b111, 12'h000, 0, 5'b10001, 0, 0, 3, 5);
        add_row(r2i16(`LA32R_OP_BLTU, 16'h0004, 6, 4), 3'b110, 12'h000, 0, 5'b10001, 0, 0, 3, 6);
        add_row(r2i16(`LA32R_OP_BGEU, 16'h7fff, 6, 4), 3'b110, 12'h000, 0, 5'b10001, 0, 0, 3, 7);
        // rk against ex, then held with the dests cleared
        next_dst = {5'd7, 5'd0, 5'd0};
        add_row(r3(`LA32R_OP_ADD_W, 7, 6, 5), 3'b110, 12'h800, 5, 5'b11000, 0, 0, 0, 0);
        add_row(r3(`LA32R_OP_ADD_W, 7, 6, 5), 3'b100, 12'h800, 5, 5'b11001, 0, 0, 0, 0);
        // rj of a taken branch against mem
        next_dst = {5'd0, 5'd6, 5'd0};
        add_row(r2i16(`LA32R_OP_BEQ, 16'h0008, 6, 4), 3'b111, 12'h000, 0, 5'b10000, 0, 0, 3, 2);
        add_row(r2i16(`LA32R_OP_BEQ, 16'h0008, 6, 4), 3'b101, 12'h000, 0, 5'b10001, 0, 0, 3, 2);
        // st.w rd on the rk port against wb
        next_dst = {5'd0, 5'd0, 5'd9};
        add_row(r2i12(`LA32R_OP_ST_W, 12'h004, 6, 9), 3'b110, 12'h800, 0, 5'b10010, 0, 3, 0, 0);
        add_row(r2i12(`LA32R_OP_ST_W, 12'h004, 6, 9), 3'b100, 12'h800, 0, 5'b10011, 0, 3, 0, 0);
        // fetch not ready for the redirect, then ready
        add_row(r2i16(`LA32R_OP_BNE, 16'h0004, 6, 4), 3'b010, 12'h000, 0, 5'b10000, 0, 0, 3, 3);
        add_row(r2i16(`LA32R_OP_BNE, 16'h0004, 6, 4), 3'b100, 12'h000, 0, 5'b10001, 0, 0, 3, 3);
    endtask

    // register data and hazards for this row, fetch shows the next one
    task automatic drive_row(input int r);
        row_t e;
        e = rows[r];
        rng = lcg_next(rng);
        rj_data_i = rng;
        rng = lcg_next(rng);
        rk_data_i = e.tie ? rj_data_i : rng;
        {ex_dest_i, mem_dest_i, wb_dest_i} = e.dst;
        if_over_i = e.ifo;
        if (r + 1 < rows.size() && rows[r + 1].nw) begin
            if_valid_i = 1'b1;
            if_pc_i    = rows[r + 1].pc;
            if_inst_i  = rows[r + 1].inst;
        end else begin
            // decoy under back-pressure, idle after the last row
            if_valid_i = (r + 1 < rows.size());
            if_pc_i    = 32'h0bad_0000;
            if_inst_i  = r3(`LA32R_OP_ADD_W, 1, 1, 1);
        end
    endtask

    task automatic check_row(input row_t e);
        la32r_isa_pkg::word_t s2;
        la32r_isa_pkg::word_t off16;
        la32r_isa_pkg::word_t tgt;
        logic                 cond;
        logic                 rk_is_rd;
        case (e.s2)
            3'd1: s2 = 32'd4;
            3'd2: s2 = {20'd0, e.inst[21:10]};
            3'd3: s2 = {{20{e.inst[21]}}, e.inst[21:10]};
            3'd4: s2 = {e.inst[24:5], 12'd0};
            3'd5: s2 = {27'd0, e.inst[14:10]};
            default: s2 = rk_data_i;
        endcase
        case (e.cd)
            3'd1: cond = 1'b1;
            3'd2: cond = (rj_data_i == rk_data_i);
            3'd3: cond = (rj_data_i != rk_data_i);
            3'd4: cond = ($signed(rj_data_i) < $signed(rk_data_i));
            3'd5: cond = ($signed(rj_data_i) >= $signed(rk_data_i));
            3'd6: cond = (rj_data_i < rk_data_i);
            3'd7: cond = (rj_data_i >= rk_data_i);
            default: cond = 1'b0;
        endcase
        // offsets count words
        off16 = {{14{e.inst[25]}}, e.inst[25:10], 2'b00};
        if (e.tk == 2'd1) tgt = rj_data_i + off16;
        else if (e.tk == 2'd2) tgt = e.pc + {{4{e.inst[9]}}, e.inst[9:0], e.inst[25:10], 2'b00};
        else tgt = e.pc + off16;
        rk_is_rd = (e.cd >= 3'd2) || e.flg[1];
        bit_eq("allow_in_o", !e.flg[4] || e.flg[0], allow_in_o);
        bit_eq("id_over_o", e.flg[0], id_over_o);
        bit_eq("jbr_taken_o", e.flg[0] && cond, jbr_taken_o);
        bit_eq("wb_we_o", e.flg[3], wb_we_o);
        bit_eq("is_load_o", e.flg[2], is_load_o);
        bit_eq("is_store_o", e.flg[1], is_store_o);
        op_eq("alu_op_o", e.op, alu_op_o);
        addr_eq("wb_addr_o", e.wa, wb_addr_o);
        word_eq("src1_o", e.s1 ? e.pc : rj_data_i, src1_o);
        word_eq("src2_o", s2, src2_o);
        word_eq("st_data_o", rk_data_i, st_data_o);
        if (e.flg[4]) begin
            addr_eq("rj_addr_o", e.inst[9:5], rj_addr_o);
            addr_eq("rk_addr_o", rk_is_rd ? e.inst[4:0] : e.inst[14:10], rk_addr_o);
            word_eq("pc_o", e.pc, pc_o);
        end
        if (e.tk != 2'd0) word_eq("jbr_target_o", tgt, jbr_target_o);
    endtask

    // watchdog sized from the table
    initial begin
        #1;
        #((rows.size() + 10) * 10);
        $display("timeout: the stimulus table did not finish in time");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk_i      = 1'b0;
        rst_n_i    = 1'b0;
        if_valid_i = 1'b0;
        if_pc_i    = '0;
        if_inst_i  = '0;
        rj_data_i  = '0;
        rk_data_i  = '0;
        ex_dest_i  = '0;
        mem_dest_i = '0;
        wb_dest_i  = '0;
        if_over_i  = 1'b1;
        build_table();
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        for (int r = 0; r < rows.size(); r++) begin
            @(negedge clk_i);
            drive_row(r);
            // sample just ahead of the rising edge
            #4;
            check_row(rows[r]);
        end
        @(negedge clk_i);
        if (dut_i.u_asserts.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("%0d bound assertion failures", dut_i.u_asserts.fail_count);
            $display("STATUS: FAIL");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/la32r_isa_pkg.sv
verilog/id_ctrl_pkg.sv
verilog/id_inst_decode.sv
verilog/id_operand_mux.sv
verilog/id_branch_unit.sv
verilog/id_hazard_unit.sv
verilog/id_stage.sv
verif/id_stage_asserts.sv
verif/id_stage_tb.sv
